// ==== dual_issue_pkg.sv ====
package dual_issue_pkg;

  localparam int DATA_W    = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // unlisted codes decode as nop
  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_slt  = 6'h05,
    op_addi = 6'h08,
    op_ori  = 6'h0d,
    op_lw   = 6'h23,
    op_sw   = 6'h2b
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_e;

  // tail[15:11] is rd for register forms, the whole tail is the immediate
  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] tail;
  } inst_t;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    sign_ext;
    logic    reg_write;
    logic    dst_is_rd;
    logic    mem_read;
    logic    mem_write;
  } ctrl_t;

  typedef struct packed {
    logic     write;
    reg_idx_t dst;
    word_t    value;
    logic     is_load;
  } fwd_t;

  typedef struct packed {
    logic     valid;
    logic     write;
    reg_idx_t rd;
    word_t    value;
  } retire_t;

  // writeback stage seen as a forwarding source, load data is final here
  function automatic fwd_t retire_to_fwd(retire_t r);
    fwd_t f;
    f.write   = r.valid & r.write;
    f.dst     = r.rd;
    f.value   = r.value;
    f.is_load = 1'b0;
    return f;
  endfunction

endpackage

// ==== inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder #(
  parameter int HAS_MEM = 1
) (
  input  dual_issue_pkg::inst_t    inst,
  input  logic                     valid,
  output dual_issue_pkg::reg_idx_t rs,
  output dual_issue_pkg::reg_idx_t rt,
  output dual_issue_pkg::reg_idx_t dst,
  output dual_issue_pkg::word_t    imm,
  output dual_issue_pkg::ctrl_t    ctrl
);

  dual_issue_pkg::ctrl_t dec;
  logic                  active;

  always_comb begin
    dec = '0;
    case (inst.opcode)
      dual_issue_pkg::op_add: begin
        dec.reg_write = 1'b1;
        dec.dst_is_rd = 1'b1;
      end
      dual_issue_pkg::op_sub: begin
        dec.alu_op    = dual_issue_pkg::alu_sub;
        dec.reg_write = 1'b1;
        dec.dst_is_rd = 1'b1;
      end
      dual_issue_pkg::op_and: begin
        dec.alu_op    = dual_issue_pkg::alu_and;
        dec.reg_write = 1'b1;
        dec.dst_is_rd = 1'b1;
      end
      dual_issue_pkg::op_or: begin
        dec.alu_op    = dual_issue_pkg::alu_or;
        dec.reg_write = 1'b1;
        dec.dst_is_rd = 1'b1;
      end
      dual_issue_pkg::op_slt: begin
        dec.alu_op    = dual_issue_pkg::alu_slt;
        dec.reg_write = 1'b1;
        dec.dst_is_rd = 1'b1;
      end
      dual_issue_pkg::op_addi: begin
        dec.use_imm   = 1'b1;
        dec.sign_ext  = 1'b1;
        dec.reg_write = 1'b1;
      end
      dual_issue_pkg::op_ori: begin
        dec.alu_op    = dual_issue_pkg::alu_or;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      dual_issue_pkg::op_lw: begin
        if (HAS_MEM != 0) begin
          dec.use_imm   = 1'b1;
          dec.sign_ext  = 1'b1;
          dec.reg_write = 1'b1;
          dec.mem_read  = 1'b1;
        end
      end
      dual_issue_pkg::op_sw: begin
        if (HAS_MEM != 0) begin
          dec.use_imm   = 1'b1;
          dec.sign_ext  = 1'b1;
          dec.mem_write = 1'b1;
        end
      end
      default: dec = '0;
    endcase
  end

  assign ctrl   = valid ? dec : '0;
  assign active = ctrl.reg_write | ctrl.mem_write;

  // unused sources read r0 so they never match a forwarding source
  assign rs  = active ? inst.rs : '0;
  assign rt  = (active && (!ctrl.use_imm || ctrl.mem_write)) ? inst.rt : '0;
  assign dst = !ctrl.reg_write ? '0 : (ctrl.dst_is_rd ? inst.tail[15:11] : inst.rt);
  assign imm = ctrl.sign_ext ? {{(dual_issue_pkg::DATA_W-16){inst.tail[15]}}, inst.tail}
                             : {{(dual_issue_pkg::DATA_W-16){1'b0}}, inst.tail};

endmodule

// ==== forward_unit.sv ====
`timescale 1ns/100ps

module forward_unit (
  input  dual_issue_pkg::reg_idx_t rs,
  input  dual_issue_pkg::reg_idx_t rt,
  input  dual_issue_pkg::fwd_t     ex_fwd0,
  input  dual_issue_pkg::fwd_t     ex_fwd1,
  input  dual_issue_pkg::fwd_t     wb_fwd0,
  input  dual_issue_pkg::fwd_t     wb_fwd1,
  input  dual_issue_pkg::word_t    rf_a,
  input  dual_issue_pkg::word_t    rf_b,
  output dual_issue_pkg::word_t    op_a,
  output dual_issue_pkg::word_t    op_b
);

  function automatic logic hit(dual_issue_pkg::fwd_t f, dual_issue_pkg::reg_idx_t src);
    return f.write && (f.dst == src) && (src != '0);
  endfunction

  // newest first, lane 1 is younger than lane 0 within a stage
  function automatic dual_issue_pkg::word_t pick(dual_issue_pkg::reg_idx_t src,
                                                 dual_issue_pkg::word_t rf);
    if (src == '0) return '0;
    if (hit(ex_fwd1, src)) return ex_fwd1.value;
    if (hit(ex_fwd0, src)) return ex_fwd0.value;
    if (hit(wb_fwd1, src)) return wb_fwd1.value;
    if (hit(wb_fwd0, src)) return wb_fwd0.value;
    return rf;
  endfunction

  function automatic logic ex_load(dual_issue_pkg::reg_idx_t src);
    if (hit(ex_fwd1, src)) return ex_fwd1.is_load;
    if (hit(ex_fwd0, src)) return ex_fwd0.is_load;
    return 1'b0;
  endfunction

  always_comb begin
    op_a = pick(rs, rf_a);
    op_b = pick(rt, rf_b);
  end

  // load data only exists from MEM/WB on, issue distance must be two or more
  always_comb begin
    no_load_from_ex: assert final (!ex_load(rs) && !ex_load(rt))
      else $error("load result consumed one cycle after issue");
  end

endmodule

// ==== data_memory.sv ====
`timescale 1ns/100ps

module data_memory #(
  parameter int MEM_DEPTH = 64
) (
  input  logic                  clk,
  input  dual_issue_pkg::word_t addr,
  input  dual_issue_pkg::word_t write_data,
  input  logic                  write,
  output dual_issue_pkg::word_t read_data
);

  localparam int ADDR_W = $clog2(MEM_DEPTH);

  dual_issue_pkg::word_t mem [MEM_DEPTH];
  logic [ADDR_W-1:0]     index;

  // word addressed, upper address bits ignored
  assign index = addr[ADDR_W-1:0];

  assign read_data = mem[index];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[index] <= write_data;
    end
  end

endmodule

// ==== exec_lane.sv ====
`timescale 1ns/100ps

module exec_lane #(
  parameter int HAS_MEM   = 1,
  parameter int MEM_DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     issue_valid,
  input  dual_issue_pkg::inst_t    inst,
  output dual_issue_pkg::reg_idx_t rs_addr,
  output dual_issue_pkg::reg_idx_t rt_addr,
  input  dual_issue_pkg::word_t    rs_data,
  input  dual_issue_pkg::word_t    rt_data,
  input  dual_issue_pkg::fwd_t     ex_fwd_in0,
  input  dual_issue_pkg::fwd_t     ex_fwd_in1,
  input  dual_issue_pkg::fwd_t     wb_in0,
  input  dual_issue_pkg::fwd_t     wb_in1,
  output dual_issue_pkg::fwd_t     ex_fwd,
  output dual_issue_pkg::retire_t  wb
);

  typedef struct packed {
    logic                  valid;
    dual_issue_pkg::inst_t inst;
  } issue_t;

  typedef struct packed {
    logic                     valid;
    dual_issue_pkg::ctrl_t    ctrl;
    dual_issue_pkg::reg_idx_t rs;
    dual_issue_pkg::reg_idx_t rt;
    dual_issue_pkg::reg_idx_t dst;
    dual_issue_pkg::word_t    imm;
    dual_issue_pkg::word_t    rs_val;
    dual_issue_pkg::word_t    rt_val;
  } id_ex_t;

  typedef struct packed {
    logic                     valid;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    dual_issue_pkg::reg_idx_t dst;
    dual_issue_pkg::word_t    result;
    dual_issue_pkg::word_t    store_data;
  } ex_mem_t;

  issue_t                   issue_q;
  id_ex_t                   id_ex;
  ex_mem_t                  ex_mem;
  dual_issue_pkg::reg_idx_t dec_dst;
  dual_issue_pkg::word_t    dec_imm;
  dual_issue_pkg::ctrl_t    dec_ctrl;
  dual_issue_pkg::word_t    op_a;
  dual_issue_pkg::word_t    op_b;
  dual_issue_pkg::word_t    alu_b;
  dual_issue_pkg::word_t    alu_y;
  dual_issue_pkg::word_t    mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // issue and decode

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_q <= '0;
    end else begin
      issue_q.valid <= issue_valid;
      issue_q.inst  <= inst;
    end
  end

  inst_decoder #(.HAS_MEM(HAS_MEM)) u_decoder (
    .inst  (issue_q.inst),
    .valid (issue_q.valid),
    .rs    (rs_addr),
    .rt    (rt_addr),
    .dst   (dec_dst),
    .imm   (dec_imm),
    .ctrl  (dec_ctrl)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else begin
      id_ex.valid  <= issue_q.valid;
      id_ex.ctrl   <= dec_ctrl;
      id_ex.rs     <= rs_addr;
      id_ex.rt     <= rt_addr;
      id_ex.dst    <= dec_dst;
      id_ex.imm    <= dec_imm;
      id_ex.rs_val <= rs_data;
      id_ex.rt_val <= rt_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // execute

  forward_unit u_forward (
    .rs      (id_ex.rs),
    .rt      (id_ex.rt),
    .ex_fwd0 (ex_fwd_in0),
    .ex_fwd1 (ex_fwd_in1),
    .wb_fwd0 (wb_in0),
    .wb_fwd1 (wb_in1),
    .rf_a    (id_ex.rs_val),
    .rf_b    (id_ex.rt_val),
    .op_a    (op_a),
    .op_b    (op_b)
  );

  always_comb begin
    alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;
    case (id_ex.ctrl.alu_op)
      dual_issue_pkg::alu_sub: alu_y = op_a - alu_b;
      dual_issue_pkg::alu_and: alu_y = op_a & alu_b;
      dual_issue_pkg::alu_or:  alu_y = op_a | alu_b;
      dual_issue_pkg::alu_slt: alu_y = dual_issue_pkg::word_t'($signed(op_a) < $signed(alu_b));
      default:                 alu_y = op_a + alu_b;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.dst        <= id_ex.dst;
      ex_mem.result     <= alu_y;
      ex_mem.store_data <= op_b;
    end
  end

  // alu result only, a load's data is not ready yet
  assign ex_fwd.write   = ex_mem.valid & ex_mem.reg_write;
  assign ex_fwd.dst     = ex_mem.dst;
  assign ex_fwd.value   = ex_mem.result;
  assign ex_fwd.is_load = ex_mem.mem_read;

  ////////////////////////////////////////////////////////////////////////////
  // memory and writeback

  if (HAS_MEM != 0) begin : g_mem
    data_memory #(.MEM_DEPTH(MEM_DEPTH)) u_dmem (
      .clk        (clk),
      .addr       (ex_mem.result),
      .write_data (ex_mem.store_data),
      .write      (ex_mem.mem_write),
      .read_data  (mem_rdata)
    );
  end else begin : g_no_mem
    assign mem_rdata = '0;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb <= '0;
    end else begin
      wb.valid <= ex_mem.valid;
      wb.write <= ex_mem.valid & ex_mem.reg_write;
      wb.rd    <= ex_mem.dst;
      wb.value <= ex_mem.mem_read ? mem_rdata : ex_mem.result;
    end
  end

  // decoder must drop lw/sw before they reach a lane with no memory
  no_mem_op: assert property (@(posedge clk) disable iff (!arst_n)
    (HAS_MEM == 0) |-> !(id_ex.ctrl.mem_read || id_ex.ctrl.mem_write))
    else $error("memory op in a lane without memory");

endmodule

// ==== register_file.sv ====
`timescale 1ns/100ps

module register_file (
  input  logic                     clk,
  input  logic                     arst_n,
  input  dual_issue_pkg::reg_idx_t rd_addr0a,
  input  dual_issue_pkg::reg_idx_t rd_addr0b,
  input  dual_issue_pkg::reg_idx_t rd_addr1a,
  input  dual_issue_pkg::reg_idx_t rd_addr1b,
  output dual_issue_pkg::word_t    rd_data0a,
  output dual_issue_pkg::word_t    rd_data0b,
  output dual_issue_pkg::word_t    rd_data1a,
  output dual_issue_pkg::word_t    rd_data1b,
  input  dual_issue_pkg::retire_t  wr0,
  input  dual_issue_pkg::retire_t  wr1
);

  localparam int NUM_REGS = 2 ** dual_issue_pkg::REG_IDX_W;

  dual_issue_pkg::word_t regs [NUM_REGS];
  logic                  we0;
  logic                  we1;

  // r0 is never written
  assign we0 = wr0.valid && wr0.write && (wr0.rd != '0);
  assign we1 = wr1.valid && wr1.write && (wr1.rd != '0);

  // lane 1 is later in program order, so it wins on both paths
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0) regs[wr0.rd] <= wr0.value;
      if (we1) regs[wr1.rd] <= wr1.value;
    end
  end

  function automatic dual_issue_pkg::word_t read_port(dual_issue_pkg::reg_idx_t a);
    if (a == '0) return '0;
    if (we1 && (wr1.rd == a)) return wr1.value;
    if (we0 && (wr0.rd == a)) return wr0.value;
    return regs[a];
  endfunction

  always_comb begin
    rd_data0a = read_port(rd_addr0a);
    rd_data0b = read_port(rd_addr0b);
    rd_data1a = read_port(rd_addr1a);
    rd_data1b = read_port(rd_addr1b);
  end

  reg0_zero: assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0)
    else $error("register 0 changed");

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/100ps

module dual_issue_core #(
  parameter int MEM_DEPTH = 64
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    issue_valid,
  input  dual_issue_pkg::inst_t   inst0,
  input  dual_issue_pkg::inst_t   inst1,
  output dual_issue_pkg::retire_t retire0,
  output dual_issue_pkg::retire_t retire1
);

  dual_issue_pkg::reg_idx_t rs_addr0;
  dual_issue_pkg::reg_idx_t rt_addr0;
  dual_issue_pkg::reg_idx_t rs_addr1;
  dual_issue_pkg::reg_idx_t rt_addr1;
  dual_issue_pkg::word_t    rs_data0;
  dual_issue_pkg::word_t    rt_data0;
  dual_issue_pkg::word_t    rs_data1;
  dual_issue_pkg::word_t    rt_data1;
  dual_issue_pkg::fwd_t     ex_fwd0;
  dual_issue_pkg::fwd_t     ex_fwd1;

  // lane 0 has no data memory
  exec_lane #(.HAS_MEM(0), .MEM_DEPTH(MEM_DEPTH)) u_lane0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .inst        (inst0),
    .rs_addr     (rs_addr0),
    .rt_addr     (rt_addr0),
    .rs_data     (rs_data0),
    .rt_data     (rt_data0),
    .ex_fwd_in0  (ex_fwd0),
    .ex_fwd_in1  (ex_fwd1),
    .wb_in0      (dual_issue_pkg::retire_to_fwd(retire0)),
    .wb_in1      (dual_issue_pkg::retire_to_fwd(retire1)),
    .ex_fwd      (ex_fwd0),
    .wb          (retire0)
  );

  exec_lane #(.HAS_MEM(1), .MEM_DEPTH(MEM_DEPTH)) u_lane1 (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .inst        (inst1),
    .rs_addr     (rs_addr1),
    .rt_addr     (rt_addr1),
    .rs_data     (rs_data1),
    .rt_data     (rt_data1),
    .ex_fwd_in0  (ex_fwd0),
    .ex_fwd_in1  (ex_fwd1),
    .wb_in0      (dual_issue_pkg::retire_to_fwd(retire0)),
    .wb_in1      (dual_issue_pkg::retire_to_fwd(retire1)),
    .ex_fwd      (ex_fwd1),
    .wb          (retire1)
  );

  register_file u_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr0a (rs_addr0),
    .rd_addr0b (rt_addr0),
    .rd_addr1a (rs_addr1),
    .rd_addr1b (rt_addr1),
    .rd_data0a (rs_data0),
    .rd_data0b (rt_data0),
    .rd_data1a (rs_data1),
    .rd_data1b (rt_data1),
    .wr0       (retire0),
    .wr1       (retire1)
  );

endmodule

// ==== dual_issue_core_checks.svh ====
`ifndef DUAL_ISSUE_CORE_CHECKS_SVH
`define DUAL_ISSUE_CORE_CHECKS_SVH

// one entry per issued pair, oldest at the front
typedef struct packed {
  logic [31:0]             issue_cycle;
  dual_issue_pkg::retire_t exp0;
  dual_issue_pkg::retire_t exp1;
} expect_t;

expect_t expect_q[$];

task automatic check_retire(string name, dual_issue_pkg::retire_t got,
                            dual_issue_pkg::retire_t exp);
  if (got.valid !== exp.valid) begin
    stop_with_failure($sformatf("Mismatch %s.valid: got %h expected %h",
                                name, got.valid, exp.valid));
  end else if (got.write !== exp.write) begin
    stop_with_failure($sformatf("Mismatch %s.write: got %h expected %h",
                                name, got.write, exp.write));
  end else if (got.rd !== exp.rd) begin
    stop_with_failure($sformatf("Mismatch %s.rd: got %h expected %h",
                                name, got.rd, exp.rd));
  end else if (got.value !== exp.value) begin
    stop_with_failure($sformatf("Mismatch %s.value: got %h expected %h",
                                name, got.value, exp.value));
  end
endtask

task automatic check_latency(int unsigned got, int unsigned exp);
  if (got != exp) begin
    stop_with_failure($sformatf("Mismatch retire latency: got %h expected %h", got, exp));
  end
endtask

// both lanes retire together, so one entry covers both records
task automatic check_retire_pair(dual_issue_pkg::retire_t got0,
                                 dual_issue_pkg::retire_t got1, int unsigned now);
  expect_t e;
  if (expect_q.size() == 0) begin
    stop_with_failure("a retire record appeared while no pair was outstanding");
  end else begin
    e = expect_q.pop_front();
    check_latency(now - e.issue_cycle, LATENCY);
    check_retire("retire0", got0, e.exp0);
    check_retire("retire1", got1, e.exp1);
  end
endtask

`endif

// ==== dual_issue_core_tb.sv ====
`timescale 1ns/100ps

module dual_issue_core_tb;

  localparam int    MEM_DEPTH    = 64;
  localparam int    CLK_HALF     = 10;
  localparam int    RESET_CYCLES = 16;
  localparam int    DRIVE_DELAY  = 2;
  localparam int    LATENCY      = 3;
  localparam string STIM_FILE    = "dual_issue_stimulus.txt";

  typedef struct packed {
    dual_issue_pkg::inst_t   inst0;
    dual_issue_pkg::inst_t   inst1;
    dual_issue_pkg::retire_t exp0;
    dual_issue_pkg::retire_t exp1;
  } pair_t;

  logic                    clk;
  logic                    arst_n;
  logic                    issue_valid;
  dual_issue_pkg::inst_t   inst0;
  dual_issue_pkg::inst_t   inst1;
  dual_issue_pkg::retire_t retire0;
  dual_issue_pkg::retire_t retire1;

  pair_t       pairs[$];
  int unsigned cycle_cnt;
  int unsigned timeout_cycles;

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  `include "dual_issue_core_checks.svh"

  dual_issue_core #(.MEM_DEPTH(MEM_DEPTH)) DUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .inst0       (inst0),
    .inst1       (inst1),
    .retire0     (retire0),
    .retire1     (retire1)
  );

  always #CLK_HALF clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus file and drive helpers

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] col [10];
    pair_t       p;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      stop_with_failure($sformatf("could not open the stimulus file %s", STIM_FILE));
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.getc(0) == "#") continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                    col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
        if (n <= 0) continue;
        if (n != 10) begin
          stop_with_failure($sformatf("stimulus line has %0d columns instead of 10", n));
        end
        p.inst0       = col[0];
        p.inst1       = col[1];
        p.exp0.valid  = col[2][0];
        p.exp0.write  = col[3][0];
        p.exp0.rd     = col[4][4:0];
        p.exp0.value  = col[5];
        p.exp1.valid  = col[6][0];
        p.exp1.write  = col[7][0];
        p.exp1.rd     = col[8][4:0];
        p.exp1.value  = col[9];
        pairs.push_back(p);
      end
      $fclose(fd);
    end
  endtask

  task automatic next_drive_slot();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic drive_idle();
    issue_valid = 1'b0;
    inst0       = '0;
    inst1       = '0;
  endtask

  // the pair is sampled at the next rising edge
  task automatic issue_pair(pair_t p);
    expect_t e;
    issue_valid   = 1'b1;
    inst0         = p.inst0;
    inst1         = p.inst1;
    e.issue_cycle = cycle_cnt + 1;
    e.exp0        = p.exp0;
    e.exp1        = p.exp1;
    expect_q.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // cycle count, timeout and retire monitor

  always @(posedge clk) begin
    if (cycle_cnt >= timeout_cycles) begin
      stop_with_failure("timeout, retire records did not drain in time");
    end
    cycle_cnt = cycle_cnt + 1;
  end

  // retire records change just after the rising edge
  always @(negedge clk) begin
    if (retire0.valid || retire1.valid) begin
      check_retire_pair(retire0, retire1, cycle_cnt);
    end
  end

  initial begin
    int unsigned bubbles;
    void'($urandom(32'h1e2c));
    clk            = 1'b0;
    arst_n         = 1'b0;
    cycle_cnt      = 0;
    timeout_cycles = 40;
    drive_idle();
    load_stimulus();
    if (pairs.size() == 0) begin
      stop_with_failure("the stimulus file holds no instruction pairs");
    end
    timeout_cycles = pairs.size() * 4 + 40;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;
    next_drive_slot();

    foreach (pairs[i]) begin
      issue_pair(pairs[i]);
      next_drive_slot();
      bubbles = $urandom % 3;
      if (bubbles != 0) begin
        drive_idle();
        repeat (bubbles) next_drive_slot();
      end
    end
    drive_idle();

    while (expect_q.size() != 0) @(negedge clk);
    // a few more cycles so a stray retire is caught
    repeat (4) @(negedge clk);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== dual_issue_stimulus.txt ====
# inst0 inst1, then lane 0 expected valid write rd value, then lane 1 the same
# every column hex, one issued pair per line
04430800 10A62000  1 1 01 00000000  1 1 04 00000000
20010005 2002FFF0  1 1 01 00000005  1 1 02 FFFFFFF0
34038001 04222000  1 1 03 00008001  1 1 04 FFFFFFF5
20250010 04A33000  1 1 05 00000015  1 1 06 00008001
08A13800 14414000  1 1 07 00000010  1 1 08 00000001
0C834800 14225000  1 1 09 00008001  1 1 0A 00000000
200B0111 200B0222  1 1 0B 00000111  1 1 0B 00000222
05606000 11676800  1 1 0C 00000222  1 1 0D 00000232
8C2E0008 AC0D0004  1 0 00 00000000  1 0 00 00000004
AC050000 8C0E0004  1 0 00 00000000  1 1 0E 00000232
20EFFFFF AC2C0003  1 1 0F 0000000F  1 0 00 00000008
05CF8000 8C110008  1 1 10 00000241  1 1 11 00000222
08019000 3613000C  1 1 12 FFFFFFFB  1 1 13 0000024D
06210000 20007FFF  1 1 00 00000227  1 1 00 00007FFF
1012A000 20150001  1 1 14 FFFFFFFB  1 1 15 00000001
0413B000 0A80B800  1 1 16 0000024D  1 1 17 FFFFFFFB
00000000 FC221234  1 0 00 00000000  1 0 00 00000000
20180100 20190200  1 1 18 00000100  1 1 19 00000200
0719D000 0B19D800  1 1 1A 00000300  1 1 1B FFFFFF00
075BE000 1778E800  1 1 1C 00000200  1 1 1D 00000001
139DF000 075CF800  1 1 1E 00000201  1 1 1F 00000500
057F0800 0FDD1000  1 1 01 00000722  1 1 02 00000001
2043FFFE AFA1000F  1 1 03 FFFFFFFF  1 0 00 00000010
14602800 8FC4FE0F  1 1 05 00000001  1 1 04 00000722
04A53000 34670000  1 1 06 00000002  1 1 07 FFFFFFFF
08864000 04874800  1 1 08 00000720  1 1 09 00000721

// ==== dual_issue_core.f ====
+incdir+.
dual_issue_pkg.sv
inst_decoder.sv
forward_unit.sv
data_memory.sv
exec_lane.sv
register_file.sv
dual_issue_core.sv
dual_issue_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing
TB_TOP    = dual_issue_core_tb
RTL_TOP   = dual_issue_core
FILELIST  = dual_issue_core.f
BUILD_DIR = obj_dir
SIM_BIN   = sim_$(TB_TOP)
LOG       = sim.log
PASS_TEXT = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
